/* Makefile */
TOP = ifu_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -f vlog.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* bench/ifu_tb.sv */
`timescale 1ns/1ns

module ifu_tb;

    localparam ifu_pkg::inst_t DATA_KEY = 32'hA5A5_0000;

    logic           clk;
    logic           reset;
    logic           r_valid;
    ifu_pkg::addr_t r_addr;
    logic           r_ready;
    ifu_pkg::inst_t r_data;
    logic           r_last;
    ifu_pkg::addr_t redirect_pc;
    logic           redirect_valid;
    logic           stall;
    logic           wb_stall;
    logic           inst_valid;
    ifu_pkg::addr_t inst_pc;
    ifu_pkg::inst_t inst;
    logic           fault;
    logic           mute;

    int             seed = 82;
    int             consumed = 0;
    ifu_pkg::addr_t last_pc;

    // expected-pc model.
    ifu_pkg::addr_t exp_pc;
    int             since_reset;
    int             req_len;
    logic           first_req;
    logic           after_consume;
    logic           held;
    ifu_pkg::addr_t held_pc;
    ifu_pkg::inst_t held_inst;
    logic           prev_r_valid;
    ifu_pkg::addr_t prev_r_addr;
    logic           fault_q;

    ifu_top i_ifu_top (
        .clk              (clk),
        .reset            (reset),
        .r_valid_o        (r_valid),
        .r_addr_o         (r_addr),
        .r_ready_i        (r_ready),
        .r_data_i         (r_data),
        .r_last_i         (r_last),
        .redirect_pc_i    (redirect_pc),
        .redirect_valid_i (redirect_valid),
        .stall_i          (stall),
        .wb_stall_i       (wb_stall),
        .inst_valid_o     (inst_valid),
        .inst_pc_o        (inst_pc),
        .inst_o           (inst),
        .fault_o          (fault)
    );

    imem_model i_imem_model (
        .clk       (clk),
        .reset     (reset),
        .mute_i    (mute),
        .r_valid_i (r_valid),
        .r_addr_i  (r_addr),
        .r_ready_o (r_ready),
        .r_data_o  (r_data),
        .r_last_o  (r_last)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else
            report_failure($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                                     name, got, expected));
    endtask

    // reference checks on every rising edge.
    always @(posedge clk) begin
        if (reset) begin
            exp_pc        = ifu_pkg::RESET_PC;
            since_reset   = 0;
            req_len       = 0;
            first_req     = 1'b1;
            after_consume = 1'b0;
            held          = 1'b0;
            prev_r_valid  = 1'b0;
            fault_q       = 1'b0;
        end else begin
            since_reset = since_reset + 1;
            if (since_reset == 1) begin
                assert (!inst_valid && !fault) else
                    report_failure("inst_valid_o or fault_o is high right after reset");
            end
            if (r_valid && first_req) begin
                assert (since_reset == 2) else
                    report_failure("first request did not start two cycles after reset");
                check_value("r_addr_o", r_addr, ifu_pkg::RESET_PC);
                first_req = 1'b0;
            end
            assert (!(r_valid && inst_valid)) else
                report_failure("a new request was made while an instruction was held");
            if (prev_r_valid && r_valid) begin
                check_value("r_addr_o", r_addr, prev_r_addr); // stable while pending.
            end
            if (after_consume) begin
                assert (r_valid) else
                    report_failure("no request in the cycle after a consume");
                check_value("r_addr_o", r_addr, exp_pc);
            end
            if (held) begin
                assert (inst_valid) else
                    report_failure("inst_valid_o dropped during a stall");
                check_value("inst_pc_o", inst_pc, held_pc);
                check_value("inst_o", inst, held_inst);
            end
            if (fault && !fault_q) begin
                assert (req_len >= int'(ifu_pkg::FETCH_TIMEOUT)
                        && req_len <= int'(ifu_pkg::FETCH_TIMEOUT) + 1) else
                    report_failure("fault_o rose after the wrong number of cycles");
            end
            if (fault_q) begin
                assert (fault && !r_valid) else
                    report_failure("fault_o cleared or a request was made before reset");
            end
            assert (!fault || mute) else
                report_failure("fault_o rose while memory was answering");
            after_consume = 1'b0;
            held          = 1'b0;
            if (inst_valid && !stall && !wb_stall) begin
                check_value("inst_pc_o", inst_pc, exp_pc);
                check_value("inst_o", inst, exp_pc ^ DATA_KEY);
                consumed      = consumed + 1;
                last_pc       = inst_pc;
                exp_pc        = redirect_valid ? redirect_pc : exp_pc + 32'd4;
                after_consume = 1'b1;
            end else if (inst_valid) begin
                held      = 1'b1; // redirect ignored under stall.
                held_pc   = inst_pc;
                held_inst = inst;
            end else if (redirect_valid && !fault) begin
                exp_pc = redirect_pc; // read in flight gets dropped.
            end
            req_len      = r_valid ? req_len + 1 : 0;
            prev_r_valid = r_valid;
            prev_r_addr  = r_addr;
            fault_q      = fault;
        end
    end

    function automatic ifu_pkg::addr_t random_target();
        return ifu_pkg::RESET_PC + (({$random(seed)} % 32'd1024) << 2);
    endfunction

    task automatic apply_reset();
        reset          = 1'b1;
        mute           = 1'b0;
        stall          = 1'b0;
        wb_stall       = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic count_consumes(input int n);
        int goal;
        int cycles;
        goal   = consumed + n;
        cycles = 0;
        while (consumed < goal) begin
            @(negedge clk);
            cycles++;
            if (cycles > 50 * n) report_failure("timed out waiting for a consumed instruction");
        end
    endtask

    task automatic await_instruction();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!inst_valid) begin
            cycles++;
            if (cycles > 100) report_failure("timed out waiting for inst_valid_o");
            @(negedge clk);
        end
    endtask

    task automatic catch_request();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!r_valid) begin
            cycles++;
            if (cycles > 100) report_failure("timed out waiting for r_valid_o");
            @(negedge clk);
        end
    endtask

    task automatic run_traffic(input int count, input logic with_redirects);
        int goal;
        int cycles;
        goal   = consumed + count;
        cycles = 0;
        while (consumed < goal) begin
            @(negedge clk);
            stall          = ({$random(seed)} % 32'd4) == 32'd0;
            wb_stall       = ({$random(seed)} % 32'd5) == 32'd0;
            redirect_valid = with_redirects && (({$random(seed)} % 32'd10) == 32'd0);
            redirect_pc    = random_target();
            cycles++;
            if (cycles > 40 * count) report_failure("timed out during random traffic");
        end
        @(negedge clk);
        stall          = 1'b0;
        wb_stall       = 1'b0;
        redirect_valid = 1'b0;
    endtask

    task automatic redirect_on_consume(input ifu_pkg::addr_t target);
        await_instruction();
        redirect_valid = 1'b1;
        redirect_pc    = target;
        @(negedge clk);
        redirect_valid = 1'b0;
        count_consumes(1);
        check_value("inst_pc_o", last_pc, target);
    endtask

    task automatic redirect_while_pending();
        ifu_pkg::addr_t old_addr;
        catch_request();
        old_addr       = r_addr;
        redirect_valid = 1'b1;
        redirect_pc    = old_addr + 32'h100;
        @(negedge clk);
        redirect_valid = 1'b0;
        count_consumes(1);
        check_value("inst_pc_o", last_pc, old_addr + 32'h100);
    endtask

    task automatic redirect_under_stall();
        ifu_pkg::addr_t kept;
        await_instruction();
        kept           = inst_pc;
        stall          = 1'b1;
        redirect_valid = 1'b1;
        redirect_pc    = 32'h2000_8000;
        @(negedge clk);
        redirect_valid = 1'b0;
        stall          = 1'b0;
        wb_stall       = 1'b1;
        @(negedge clk);
        wb_stall = 1'b0;
        count_consumes(2);
        check_value("inst_pc_o", last_pc, kept + 32'd4);
    endtask

    task automatic mute_until_fault();
        int cycles;
        await_instruction();
        mute   = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!fault) begin
            cycles++;
            if (cycles > 4 * int'(ifu_pkg::FETCH_TIMEOUT)) begin
                report_failure("timed out waiting for fault_o");
            end
            @(negedge clk);
        end
        repeat (20) @(negedge clk); // fault must hold with the bus quiet.
    endtask

    initial begin
        clk = 1'b0;
        apply_reset();
        run_traffic(40, 1'b0);
        redirect_on_consume(32'h2000_4000);
        redirect_while_pending();
        redirect_under_stall();
        run_traffic(40, 1'b1);
        mute_until_fault();
        apply_reset();
        run_traffic(12, 1'b1);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* bench/imem_model.sv */
`timescale 1ns/1ns

module imem_model (
    input  logic           clk,
    input  logic           reset,
    input  logic           mute_i,
    input  logic           r_valid_i,
    input  ifu_pkg::addr_t r_addr_i,
    output logic           r_ready_o,
    output ifu_pkg::inst_t r_data_o,
    output logic           r_last_o
);

    localparam ifu_pkg::inst_t DATA_KEY = 32'hA5A5_0000;

    int             seed = 82;
    int             lat;
    int             wait_cnt = 0;
    logic           busy = 1'b0;
    logic           ready = 1'b0;
    ifu_pkg::inst_t data = '0;

    // answers change on the falling edge.
    always @(negedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            ready <= 1'b0;
        end else if (ready) begin
            busy  <= 1'b0; // beat was taken on the last rising edge.
            ready <= 1'b0;
        end else if (busy && !mute_i) begin
            if (wait_cnt == 0) begin
                ready <= 1'b1;
                data  <= r_addr_i ^ DATA_KEY;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (!busy && r_valid_i && !mute_i) begin
            lat = {$random(seed)} % 32'd6; // 0 to 5 extra cycles.
            busy <= 1'b1;
            if (lat == 0) begin
                ready <= 1'b1;
                data  <= r_addr_i ^ DATA_KEY;
            end else begin
                wait_cnt <= lat - 1;
            end
        end
    end

    assign r_ready_o = ready;
    assign r_last_o  = ready; // single beat.
    assign r_data_o  = data;

endmodule

/* hdl/fetch_fsm.sv */
`timescale 1ns/1ns

module fetch_fsm (
    input  logic clk,
    input  logic reset,
    input  logic r_ready_i,
    input  logic r_last_i,
    input  logic stall_i,
    input  logic wb_stall_i,
    input  logic redirect_valid_i,
    input  logic redirect_pending_i,
    input  logic timed_out_i,
    output logic r_valid_o,
    output logic pc_advance_o,
    output logic buf_load_o,
    output logic buf_clear_o,
    output logic timer_run_o,
    output logic fault_o
);

    ifu_pkg::fetch_state_t state;
    ifu_pkg::fetch_state_t state_nxt;

    logic stall_any;
    logic accept;
    logic stale;
    logic consume;

    // decode and write-back stalls both hold the buffered instruction.
    assign stall_any = stall_i | wb_stall_i;

    // single beat, so ready counts only together with last.
    assign accept = (state == ifu_pkg::ST_REQ) & r_ready_i & r_last_i;

    // a redirect seen during the read makes its data useless.
    assign stale = redirect_pending_i | redirect_valid_i;

    assign consume = (state == ifu_pkg::ST_HOLD) & ~stall_any;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ifu_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ifu_pkg::ST_IDLE: begin
                state_nxt = ifu_pkg::ST_REQ;
            end
            ifu_pkg::ST_REQ: begin
                if (accept) begin
                    // dropped data goes back through idle so valid drops a cycle.
                    state_nxt = stale ? ifu_pkg::ST_IDLE : ifu_pkg::ST_HOLD;
                end else if (timed_out_i) begin
                    state_nxt = ifu_pkg::ST_FAULT;
                end
            end
            ifu_pkg::ST_HOLD: begin
                if (consume) begin
                    state_nxt = ifu_pkg::ST_REQ;
                end
            end
            ifu_pkg::ST_FAULT: begin
                state_nxt = ifu_pkg::ST_FAULT; // only reset leaves.
            end
            default: begin
                state_nxt = ifu_pkg::ST_IDLE;
            end
        endcase
    end

    assign r_valid_o   = (state == ifu_pkg::ST_REQ);
    assign timer_run_o = (state == ifu_pkg::ST_REQ);
    assign fault_o     = (state == ifu_pkg::ST_FAULT);

    assign buf_load_o  = accept & ~stale;
    assign buf_clear_o = consume;

    // pc moves on consumption, or right away when the response is dropped.
    assign pc_advance_o = consume | (accept & stale);

endmodule

/* hdl/fetch_timer.sv */
`timescale 1ns/1ns

module fetch_timer (
    input  logic clk,
    input  logic reset,
    input  logic run_i,
    output logic timed_out_o
);

    ifu_pkg::timer_t count;
    logic            at_limit;

    assign at_limit = (count == ifu_pkg::FETCH_TIMEOUT);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (!run_i) begin
            count <= '0; // restarts with every request.
        end else if (!at_limit) begin
            count <= count + 7'd1;
        end
    end

    // count sits at the limit until run drops.
    assign timed_out_o = at_limit;

endmodule

/* hdl/ifu_pkg.sv */
package ifu_pkg;

    // pc and bus address.
    typedef logic [31:0] addr_t;

    // one instruction word.
    typedef logic [31:0] inst_t;

    // cycle count of a pending read.
    typedef logic [6:0] timer_t;

    // first fetch address after reset.
    localparam addr_t RESET_PC = 32'h2000_0000;

    // no compressed instructions, so the step is fixed.
    localparam addr_t INST_BYTES = 32'd4;

    // cycles a read may stay pending before the access fault.
    localparam timer_t FETCH_TIMEOUT = 7'd64;

    // fetch sequencing.
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0, // one quiet cycle before a request.
        ST_REQ   = 2'd1, // read pending on the bus.
        ST_HOLD  = 2'd2, // instruction waits in the buffer for decode.
        ST_FAULT = 2'd3  // held until reset once memory fails to answer.
    } fetch_state_t;

endpackage

/* hdl/ifu_top.sv */
`timescale 1ns/1ns

module ifu_top (
    input  logic           clk,
    input  logic           reset,

    // read bus.
    output logic           r_valid_o,
    output ifu_pkg::addr_t r_addr_o,
    input  logic           r_ready_i,
    input  ifu_pkg::inst_t r_data_i,
    input  logic           r_last_i,

    // pipeline side.
    input  ifu_pkg::addr_t redirect_pc_i,
    input  logic           redirect_valid_i,
    input  logic           stall_i,
    input  logic           wb_stall_i,
    output logic           inst_valid_o,
    output ifu_pkg::addr_t inst_pc_o,
    output ifu_pkg::inst_t inst_o,
    output logic           fault_o
);

    logic           pc_advance;
    logic           timer_run;
    logic           timed_out;
    logic           buf_load;
    logic           buf_clear;
    logic           redirect_pending;
    ifu_pkg::addr_t pc;

    fetch_fsm i_fetch_fsm (
        .clk                (clk),
        .reset              (reset),
        .r_ready_i          (r_ready_i),
        .r_last_i           (r_last_i),
        .stall_i            (stall_i),
        .wb_stall_i         (wb_stall_i),
        .redirect_valid_i   (redirect_valid_i),
        .redirect_pending_i (redirect_pending),
        .timed_out_i        (timed_out),
        .r_valid_o          (r_valid_o),
        .pc_advance_o       (pc_advance),
        .buf_load_o         (buf_load),
        .buf_clear_o        (buf_clear),
        .timer_run_o        (timer_run),
        .fault_o            (fault_o)
    );

    fetch_timer i_fetch_timer (
        .clk         (clk),
        .reset       (reset),
        .run_i       (timer_run),
        .timed_out_o (timed_out)
    );

    pc_gen i_pc_gen (
        .clk                (clk),
        .reset              (reset),
        .advance_i          (pc_advance),
        .redirect_valid_i   (redirect_valid_i),
        .redirect_pc_i      (redirect_pc_i),
        .buf_load_i         (buf_load),
        .pc_o               (pc),
        .redirect_pending_o (redirect_pending)
    );

    inst_buffer i_inst_buffer (
        .clk     (clk),
        .reset   (reset),
        .load_i  (buf_load),
        .clear_i (buf_clear),
        .pc_i    (pc),
        .data_i  (r_data_i),
        .valid_o (inst_valid_o),
        .pc_o    (inst_pc_o),
        .inst_o  (inst_o)
    );

    assign r_addr_o = pc; // held while the read is pending.

endmodule

/* hdl/inst_buffer.sv */
`timescale 1ns/1ns

module inst_buffer (
    input  logic           clk,
    input  logic           reset,
    input  logic           load_i,
    input  logic           clear_i,
    input  ifu_pkg::addr_t pc_i,
    input  ifu_pkg::inst_t data_i,
    output logic           valid_o,
    output ifu_pkg::addr_t pc_o,
    output ifu_pkg::inst_t inst_o
);

    logic           valid;
    ifu_pkg::addr_t pc_q;
    ifu_pkg::inst_t inst_q;

    // the fsm never loads and clears in the same cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (clear_i) begin
            valid <= 1'b0;
        end else if (load_i) begin
            valid <= 1'b1;
        end
    end

    // pc is still the read address on the accepting edge.
    always_ff @(posedge clk) begin
        if (load_i) begin
            pc_q   <= pc_i;
            inst_q <= data_i;
        end
    end

    assign valid_o = valid;
    assign pc_o    = pc_q;
    assign inst_o  = inst_q;

endmodule

/* hdl/pc_gen.sv */
`timescale 1ns/1ns

module pc_gen (
    input  logic          clk,
    input  logic          reset,
    input  logic          advance_i,
    input  logic          redirect_valid_i,
    input  ifu_pkg::addr_t redirect_pc_i,
    input  logic          buf_load_i,
    output ifu_pkg::addr_t pc_o,
    output logic          redirect_pending_o
);

    ifu_pkg::addr_t pc;
    ifu_pkg::addr_t pc_nxt;
    ifu_pkg::addr_t pending_pc;
    logic           pending;
    logic           holding;

    // fresh redirect wins over an older pending one.
    always_comb begin
        if (redirect_valid_i) begin
            pc_nxt = redirect_pc_i;
        end else if (pending) begin
            pc_nxt = pending_pc;
        end else begin
            pc_nxt = pc + ifu_pkg::INST_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= ifu_pkg::RESET_PC;
        end else if (advance_i) begin
            pc <= pc_nxt;
        end
    end

    // set while an instruction sits in the buffer.
    always_ff @(posedge clk) begin
        if (reset) begin
            holding <= 1'b0;
        end else if (advance_i) begin
            holding <= 1'b0;
        end else if (buf_load_i) begin
            holding <= 1'b1;
        end
    end

    // redirects during a held, stalled instruction are left to the pipeline.
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (advance_i) begin
            pending <= 1'b0;
        end else if (redirect_valid_i && !holding) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!advance_i && redirect_valid_i && !holding) begin
            pending_pc <= redirect_pc_i;
        end
    end

    assign pc_o               = pc;
    assign redirect_pending_o = pending;

endmodule

/* vlog.f */
hdl/ifu_pkg.sv
hdl/fetch_fsm.sv
hdl/fetch_timer.sv
hdl/pc_gen.sv
hdl/inst_buffer.sv
hdl/ifu_top.sv
bench/imem_model.sv
bench/ifu_tb.sv
